//--- raster_cfg.svh
// fixed 320x240 buffer scanned at half resolution; FB_AW must cover width times height
`ifndef RASTER_CFG_SVH
`define RASTER_CFG_SVH

// screen size in buffer pixels
`define RASTER_FB_WIDTH 320
`define RASTER_FB_HEIGHT 240

// 320*240 = 76800 bytes, needs 17 address bits
`define RASTER_FB_AW 17

// axi4-lite slave bus, four 32-bit words
`define RASTER_AXI_AW 4
`define RASTER_AXI_DW 32

// default number of queued triangles
`define RASTER_FIFO_DEPTH 8

// value written to every pixel on a clear
`define RASTER_CLEAR_COLOR 0

`endif

//--- raster_pkg.sv
// shared record types only; field widths assume the screen size in the cfg header
`include "raster_cfg.svh"

package raster_pkg;

  // one screen vertex
  // x needs 9 bits to reach column 319
  typedef struct packed {
    logic [8:0] x;
    logic [7:0] y;
  } vertex_t;

  // one queued triangle, 59 bits
  typedef struct packed {
    vertex_t    v1;
    vertex_t    v2;
    vertex_t    v3;
    logic [7:0] color;
  } triangle_t;

  // screen-clamped bounding box, 34 bits
  typedef struct packed {
    logic [8:0] x_min;
    logic [8:0] x_max;
    logic [7:0] y_min;
    logic [7:0] y_max;
  } bbox_t;

  // single pixel write into the frame buffer
  typedef struct packed {
    logic                     we;
    logic [`RASTER_FB_AW-1:0] addr;
    logic [7:0]               color;
  } fb_write_t;

  // frame controller phases
  typedef enum logic [1:0] {
    clear_buf,
    wait_tri,
    calc_bbox,
    fill
  } frame_state_e;

endpackage

//--- axi_tri_regs.sv
// write-only slave, one write in flight, no strobes; only awaddr[3:2] selects a word
`timescale 1ns/1ps
`include "raster_cfg.svh"

module axi_tri_regs (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  logic [`RASTER_AXI_AW-1:0] S_AXI_AWADDR,
  input  logic                      S_AXI_AWVALID,
  output logic                      S_AXI_AWREADY,
  input  logic [`RASTER_AXI_DW-1:0] S_AXI_WDATA,
  input  logic                      S_AXI_WVALID,
  output logic                      S_AXI_WREADY,
  output logic [1:0]                S_AXI_BRESP,
  output logic                      S_AXI_BVALID,
  input  logic                      S_AXI_BREADY,
  input  logic                      fifo_full,
  output logic                      tri_push,
  output raster_pkg::triangle_t     tri_data
);

  logic [`RASTER_AXI_AW-1:0] axi_awaddr;
  logic                      axi_awready;
  logic                      axi_wready;
  logic                      axi_bvalid;
  logic                      aw_en;
  logic                      accept;
  logic                      wr_en;
  logic [1:0]                word_idx;
  raster_pkg::vertex_t       vtx_reg [3];
  logic [7:0]                color_reg;

  assign S_AXI_AWREADY = axi_awready;
  assign S_AXI_WREADY  = axi_wready;
  assign S_AXI_BVALID  = axi_bvalid;
  // always OKAY
  assign S_AXI_BRESP   = 2'b00;

  ////////////////////
  // address and data acceptance
  // both valids seen with no response pending, ready pulses next cycle
  assign accept   = !axi_awready && S_AXI_AWVALID && S_AXI_WVALID && aw_en;
  assign wr_en    = axi_awready && S_AXI_AWVALID && axi_wready && S_AXI_WVALID;
  assign word_idx = axi_awaddr[3:2];

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      axi_awready <= 1'b0;
      axi_wready  <= 1'b0;
      aw_en       <= 1'b1;
    end else begin
      // one-shot, ready drops on its own the cycle after
      axi_awready <= accept;
      axi_wready  <= accept;
      if (accept) begin
        aw_en <= 1'b0;
      end else if (S_AXI_BREADY && axi_bvalid) begin
        // response taken, next write may start
        aw_en <= 1'b1;
      end
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (accept) begin
      axi_awaddr <= S_AXI_AWADDR;
    end
  end

  ////////////////////
  // write response
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      axi_bvalid <= 1'b0;
    end else if (wr_en && !axi_bvalid) begin
      axi_bvalid <= 1'b1;
    end else if (S_AXI_BREADY && axi_bvalid) begin
      axi_bvalid <= 1'b0;
    end
  end

  ////////////////////
  // triangle registers and commit
  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_en) begin
      if (word_idx == 2'd3) begin
        color_reg <= S_AXI_WDATA[7:0];
      end else begin
        // x in bits 8..0, y in bits 23..16
        vtx_reg[word_idx] <= '{x: S_AXI_WDATA[8:0], y: S_AXI_WDATA[23:16]};
      end
    end
  end

  // push lands the cycle after the color write, when color_reg already holds the new value
  // a commit into a full fifo is simply lost
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      tri_push <= 1'b0;
    end else begin
      tri_push <= wr_en && (word_idx == 2'd3) && !fifo_full;
    end
  end

  assign tri_data = '{v1: vtx_reg[0], v2: vtx_reg[1], v3: vtx_reg[2], color: color_reg};

endmodule

//--- tri_fifo.sv
// head is read straight from memory at the read pointer; push when full and pop when empty are ignored
`timescale 1ns/1ps
`include "raster_cfg.svh"

module tri_fifo #(
  parameter int DEPTH = `RASTER_FIFO_DEPTH
) (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  input  logic                  push,
  input  raster_pkg::triangle_t push_data,
  input  logic                  pop,
  output raster_pkg::triangle_t head,
  output logic                  full,
  output logic                  empty
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  raster_pkg::triangle_t mem [DEPTH];
  logic [PW-1:0]         wr_ptr;
  logic [PW-1:0]         rd_ptr;
  logic [CW-1:0]         count;
  logic                  do_push;
  logic                  do_pop;

  // wrap also works for a depth that is not a power of two
  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
    if (ptr == PW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full    = (count == CW'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr];

  always_ff @(posedge S_AXI_ACLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- bbox_fill.sv
// fills the whole clamped bounding box, not the exact triangle; start is expected only while idle
`timescale 1ns/1ps
`include "raster_cfg.svh"

module bbox_fill (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  input  logic                  start,
  input  raster_pkg::triangle_t tri_in,
  output logic                  done,
  output raster_pkg::fb_write_t fb_wr
);

  localparam int AW = `RASTER_FB_AW;
  localparam logic [8:0] X_LAST = 9'(`RASTER_FB_WIDTH - 1);
  localparam logic [8:0] Y_LAST = 9'(`RASTER_FB_HEIGHT - 1);

  raster_pkg::bbox_t box_next;
  raster_pkg::bbox_t box;
  logic [8:0]        x_cnt;
  logic [7:0]        y_cnt;
  logic [7:0]        color;
  logic              busy;
  logic              wr_q;
  logic [AW-1:0]     addr_q;
  logic [AW-1:0]     pix_addr;
  logic              last_pix;

  function automatic logic [8:0] min3(input logic [8:0] a, input logic [8:0] b,
                                      input logic [8:0] c);
    logic [8:0] m;
    m = (a < b) ? a : b;
    return (m < c) ? m : c;
  endfunction

  function automatic logic [8:0] max3(input logic [8:0] a, input logic [8:0] b,
                                      input logic [8:0] c);
    logic [8:0] m;
    m = (a > b) ? a : b;
    return (m > c) ? m : c;
  endfunction

  function automatic logic [8:0] clamp(input logic [8:0] v, input logic [8:0] lim);
    return (v > lim) ? lim : v;
  endfunction

  ////////////////////
  // box from the vertex extremes
  // minima are clamped too so an off-screen box still ends
  always_comb begin
    box_next.x_min = clamp(min3(tri_in.v1.x, tri_in.v2.x, tri_in.v3.x), X_LAST);
    box_next.x_max = clamp(max3(tri_in.v1.x, tri_in.v2.x, tri_in.v3.x), X_LAST);
    box_next.y_min = 8'(clamp(min3({1'b0, tri_in.v1.y}, {1'b0, tri_in.v2.y},
                                   {1'b0, tri_in.v3.y}), Y_LAST));
    box_next.y_max = 8'(clamp(max3({1'b0, tri_in.v1.y}, {1'b0, tri_in.v2.y},
                                   {1'b0, tri_in.v3.y}), Y_LAST));
  end

  ////////////////////
  // raster walk, row by row
  assign pix_addr = AW'(y_cnt) * AW'(`RASTER_FB_WIDTH) + AW'(x_cnt);
  assign last_pix = (x_cnt == box.x_max) && (y_cnt == box.y_max);

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      busy <= 1'b0;
      wr_q <= 1'b0;
      done <= 1'b0;
    end else begin
      // write is registered, so done trails the last visible write by one
      wr_q <= busy;
      done <= wr_q && !busy;
      if (start) begin
        busy <= 1'b1;
      end else if (busy && last_pix) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (start) begin
      box   <= box_next;
      x_cnt <= box_next.x_min;
      y_cnt <= box_next.y_min;
      color <= tri_in.color;
    end else if (busy) begin
      addr_q <= pix_addr;
      if (x_cnt == box.x_max) begin
        x_cnt <= box.x_min;
        y_cnt <= y_cnt + 1'b1;
      end else begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  assign fb_wr = '{we: wr_q, addr: addr_q, color: color};

endmodule

//--- frame_ctrl.sv
// a vsync edge only counts in wait_tri; a triangle in progress always completes first
`timescale 1ns/1ps
`include "raster_cfg.svh"

module frame_ctrl (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  input  logic                  vsync,
  input  logic                  tri_valid,
  input  raster_pkg::triangle_t tri_head,
  input  logic                  fill_done,
  input  raster_pkg::fb_write_t fill_wr,
  output logic                  tri_pop,
  output logic                  fill_start,
  output raster_pkg::triangle_t fill_tri,
  output raster_pkg::fb_write_t fb_wr
);

  localparam int AW = `RASTER_FB_AW;
  localparam logic [AW-1:0] CLEAR_LAST = AW'(`RASTER_FB_WIDTH * `RASTER_FB_HEIGHT - 1);
  localparam logic [7:0] CLEAR_COLOR = 8'(`RASTER_CLEAR_COLOR);

  raster_pkg::frame_state_e state;
  logic [AW-1:0]            clear_addr;
  logic                     vsync_s1;
  logic                     vsync_s2;
  logic                     vsync_prev;
  logic                     vsync_rise;

  ////////////////////
  // vsync sync and edge detect
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      vsync_s1   <= 1'b0;
      vsync_s2   <= 1'b0;
      vsync_prev <= 1'b0;
    end else begin
      vsync_s1   <= vsync;
      vsync_s2   <= vsync_s1;
      vsync_prev <= vsync_s2;
    end
  end

  assign vsync_rise = vsync_s2 && !vsync_prev;

  // pop and latch share one edge; vsync wins over a waiting triangle
  assign tri_pop    = (state == raster_pkg::wait_tri) && tri_valid && !vsync_rise;
  // start lasts exactly the one calc_bbox cycle
  assign fill_start = (state == raster_pkg::calc_bbox);

  // clear stream owns the buffer port only while clearing
  always_comb begin
    if (state == raster_pkg::clear_buf) begin
      fb_wr = '{we: 1'b1, addr: clear_addr, color: CLEAR_COLOR};
    end else begin
      fb_wr = fill_wr;
    end
  end

  ////////////////////
  // frame fsm
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state      <= raster_pkg::clear_buf;
      clear_addr <= '0;
    end else begin
      case (state)
        raster_pkg::clear_buf: begin
          // one pixel per cycle over the whole buffer
          if (clear_addr == CLEAR_LAST) begin
            clear_addr <= '0;
            state      <= raster_pkg::wait_tri;
          end else begin
            clear_addr <= clear_addr + 1'b1;
          end
        end
        raster_pkg::wait_tri: begin
          if (vsync_rise) begin
            state <= raster_pkg::clear_buf;
          end else if (tri_valid) begin
            state <= raster_pkg::calc_bbox;
          end
        end
        raster_pkg::calc_bbox: begin
          state <= raster_pkg::fill;
        end
        raster_pkg::fill: begin
          if (fill_done) begin
            state <= raster_pkg::wait_tri;
          end
        end
      endcase
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (tri_pop) begin
      fill_tri <= tri_head;
    end
  end

endmodule

//--- frame_buffer.sv
// no reset; contents are undefined until the first clear, and drawX/2 beyond 319 reads garbage
`timescale 1ns/1ps
`include "raster_cfg.svh"

module frame_buffer (
  input  logic                  S_AXI_ACLK,
  input  raster_pkg::fb_write_t fb_wr,
  input  logic [9:0]            drawX,
  input  logic [9:0]            drawY,
  output logic [3:0]            red,
  output logic [3:0]            green,
  output logic [3:0]            blue
);

  localparam int AW    = `RASTER_FB_AW;
  localparam int DEPTH = `RASTER_FB_WIDTH * `RASTER_FB_HEIGHT;

  logic [7:0]    mem [DEPTH];
  logic [AW-1:0] scan_addr;
  logic [7:0]    scan_pix;

  // write port from the frame controller
  always_ff @(posedge S_AXI_ACLK) begin
    if (fb_wr.we) begin
      mem[fb_wr.addr] <= fb_wr.color;
    end
  end

  ////////////////////
  // scan-out, each buffer pixel covers 2x2 display pixels
  assign scan_addr = AW'(drawY[9:1]) * AW'(`RASTER_FB_WIDTH) + AW'(drawX[9:1]);
  assign scan_pix  = mem[scan_addr];

  // rrrgggbb widened to 4 bits per channel with zero fill
  always_ff @(posedge S_AXI_ACLK) begin
    red   <= {scan_pix[7:5], 1'b0};
    green <= {scan_pix[4:2], 1'b0};
    blue  <= {scan_pix[1:0], 2'b00};
  end

endmodule

//--- tri_raster_top.sv
// one clock domain; vsync may be asynchronous, drawX/drawY must be synchronous to S_AXI_ACLK
`timescale 1ns/1ps
`include "raster_cfg.svh"

module tri_raster_top (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  logic [`RASTER_AXI_AW-1:0] S_AXI_AWADDR,
  input  logic                      S_AXI_AWVALID,
  output logic                      S_AXI_AWREADY,
  input  logic [`RASTER_AXI_DW-1:0] S_AXI_WDATA,
  input  logic                      S_AXI_WVALID,
  output logic                      S_AXI_WREADY,
  output logic [1:0]                S_AXI_BRESP,
  output logic                      S_AXI_BVALID,
  input  logic                      S_AXI_BREADY,
  input  logic                      vsync,
  input  logic [9:0]                drawX,
  input  logic [9:0]                drawY,
  output logic [3:0]                red,
  output logic [3:0]                green,
  output logic [3:0]                blue
);

  logic                  tri_push;
  raster_pkg::triangle_t tri_data;
  logic                  fifo_full;
  logic                  fifo_empty;
  logic                  tri_valid;
  raster_pkg::triangle_t fifo_head;
  logic                  tri_pop;
  logic                  fill_start;
  raster_pkg::triangle_t fill_tri;
  logic                  fill_done;
  raster_pkg::fb_write_t fill_wr;
  raster_pkg::fb_write_t fb_wr;

  // controller wants a valid flag
  assign tri_valid = !fifo_empty;

  ////////////////////
  // host side
  axi_tri_regs axi_tri_regs_inst (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .S_AXI_AWADDR (S_AXI_AWADDR),
    .S_AXI_AWVALID(S_AXI_AWVALID),
    .S_AXI_AWREADY(S_AXI_AWREADY),
    .S_AXI_WDATA  (S_AXI_WDATA),
    .S_AXI_WVALID (S_AXI_WVALID),
    .S_AXI_WREADY (S_AXI_WREADY),
    .S_AXI_BRESP  (S_AXI_BRESP),
    .S_AXI_BVALID (S_AXI_BVALID),
    .S_AXI_BREADY (S_AXI_BREADY),
    .fifo_full    (fifo_full),
    .tri_push     (tri_push),
    .tri_data     (tri_data)
  );

  tri_fifo #(
    .DEPTH(`RASTER_FIFO_DEPTH)
  ) tri_fifo_inst (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .push         (tri_push),
    .push_data    (tri_data),
    .pop          (tri_pop),
    .head         (fifo_head),
    .full         (fifo_full),
    .empty        (fifo_empty)
  );

  ////////////////////
  // drawing side
  frame_ctrl frame_ctrl_inst (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .vsync        (vsync),
    .tri_valid    (tri_valid),
    .tri_head     (fifo_head),
    .fill_done    (fill_done),
    .fill_wr      (fill_wr),
    .tri_pop      (tri_pop),
    .fill_start   (fill_start),
    .fill_tri     (fill_tri),
    .fb_wr        (fb_wr)
  );

  bbox_fill bbox_fill_inst (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .start        (fill_start),
    .tri_in       (fill_tri),
    .done         (fill_done),
    .fb_wr        (fill_wr)
  );

  frame_buffer frame_buffer_inst (
    .S_AXI_ACLK(S_AXI_ACLK),
    .fb_wr     (fb_wr),
    .drawX     (drawX),
    .drawY     (drawY),
    .red       (red),
    .green     (green),
    .blue      (blue)
  );

endmodule

//--- tb_clk_gen.sv
// free-running 100 ns clock; reset is held low for the first two rising edges
`timescale 1ns/1ps

module tb_clk_gen (
  output logic S_AXI_ACLK,
  output logic S_AXI_ARESETN
);

  initial begin
    S_AXI_ACLK = 1'b0;
    forever #50 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // release away from the active edge
  initial begin
    S_AXI_ARESETN = 1'b0;
    repeat (2) @(posedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
  end

endmodule

//--- tri_raster_sva.sv
// bound twice; the ports that a target module does not have are tied low in its bind
`timescale 1ns/1ps
`include "raster_cfg.svh"

module tri_raster_sva (
  input logic                     S_AXI_ACLK,
  input logic                     S_AXI_ARESETN,
  input logic                     awvalid,
  input logic                     wvalid,
  input logic                     awready,
  input logic                     wready,
  input logic                     bvalid,
  input logic                     bready,
  input logic                     fb_we,
  input logic [`RASTER_FB_AW-1:0] fb_addr
);

  localparam logic [`RASTER_FB_AW-1:0] PIXELS =
    `RASTER_FB_AW'(`RASTER_FB_WIDTH * `RASTER_FB_HEIGHT);

  ////////////////////
  // axi write channel
  // both valids with nothing outstanding bring both readies on the next edge
  a_ready_after_valids: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    awvalid && wvalid && !awready && !bvalid |=> awready && wready)
    else $error("ready did not follow awvalid and wvalid");

  // one write in flight, no new ready while the response waits
  a_no_ready_outstanding: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    bvalid |-> !awready && !wready)
    else $error("ready raised while a write response is outstanding");

  // response waits for bready
  a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  ////////////////////
  // frame buffer writes stay on screen
  a_fb_range: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    fb_we |-> fb_addr < PIXELS)
    else $error("frame buffer write beyond last pixel");

endmodule

bind axi_tri_regs tri_raster_sva axi_sva_inst (
  .S_AXI_ACLK   (S_AXI_ACLK),
  .S_AXI_ARESETN(S_AXI_ARESETN),
  .awvalid      (S_AXI_AWVALID),
  .wvalid       (S_AXI_WVALID),
  .awready      (S_AXI_AWREADY),
  .wready       (S_AXI_WREADY),
  .bvalid       (S_AXI_BVALID),
  .bready       (S_AXI_BREADY),
  .fb_we        (1'b0),
  .fb_addr      ('0)
);

bind frame_ctrl tri_raster_sva fb_sva_inst (
  .S_AXI_ACLK   (S_AXI_ACLK),
  .S_AXI_ARESETN(S_AXI_ARESETN),
  .awvalid      (1'b0),
  .wvalid       (1'b0),
  .awready      (1'b0),
  .wready       (1'b0),
  .bvalid       (1'b0),
  .bready       (1'b0),
  .fb_we        (fb_wr.we),
  .fb_addr      (fb_wr.addr)
);

//--- tri_raster_tb.sv
// runs from the project root so tri_raster_tests.txt is found; waits are bounds from timing rules
`timescale 1ns/1ps
`include "raster_cfg.svh"

module tri_raster_tb;

  localparam int CLEAR_CYCLES = `RASTER_FB_WIDTH * `RASTER_FB_HEIGHT;
  localparam int MARGIN       = 16;
  localparam int MAX_RECORDS  = 32;
  localparam int REC_WORDS    = 5;

  logic        S_AXI_ACLK;
  logic        S_AXI_ARESETN;
  logic [3:0]  S_AXI_AWADDR;
  logic        S_AXI_AWVALID;
  logic        S_AXI_AWREADY;
  logic [31:0] S_AXI_WDATA;
  logic        S_AXI_WVALID;
  logic        S_AXI_WREADY;
  logic [1:0]  S_AXI_BRESP;
  logic        S_AXI_BVALID;
  logic        S_AXI_BREADY;
  logic        vsync;
  logic [9:0]  drawX;
  logic [9:0]  drawY;
  logic [3:0]  red;
  logic [3:0]  green;
  logic [3:0]  blue;

  // records of kind, then four words
  logic [31:0] words [MAX_RECORDS*REC_WORDS];
  logic [15:0] lfsr;
  logic        loaded;
  int          num_records;
  int          pending;
  int          test_errors;
  int          tests_run;
  int          tests_failed;

  tb_clk_gen tb_clk_gen_inst (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN)
  );

  tri_raster_top tri_raster_top_inst (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .S_AXI_AWADDR (S_AXI_AWADDR),
    .S_AXI_AWVALID(S_AXI_AWVALID),
    .S_AXI_AWREADY(S_AXI_AWREADY),
    .S_AXI_WDATA  (S_AXI_WDATA),
    .S_AXI_WVALID (S_AXI_WVALID),
    .S_AXI_WREADY (S_AXI_WREADY),
    .S_AXI_BRESP  (S_AXI_BRESP),
    .S_AXI_BVALID (S_AXI_BVALID),
    .S_AXI_BREADY (S_AXI_BREADY),
    .vsync        (vsync),
    .drawX        (drawX),
    .drawY        (drawY),
    .red          (red),
    .green        (green),
    .blue         (blue)
  );

  ////////////////////
  // helpers
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
    test_errors++;
  endtask

  // galois lfsr, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic close_test(input string label);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", tests_run, label);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, label, test_errors);
    end
    test_errors = 0;
  endtask

  // clamped box size from the vertex words
  function automatic int bbox_area(input logic [31:0] a, input logic [31:0] b,
                                   input logic [31:0] c);
    int xv [3];
    int yv [3];
    int x_lo;
    int x_hi;
    int y_lo;
    int y_hi;
    xv[0] = int'(a[8:0]);
    xv[1] = int'(b[8:0]);
    xv[2] = int'(c[8:0]);
    yv[0] = int'(a[23:16]);
    yv[1] = int'(b[23:16]);
    yv[2] = int'(c[23:16]);
    x_lo = xv[0];
    x_hi = xv[0];
    y_lo = yv[0];
    y_hi = yv[0];
    for (int i = 1; i < 3; i++) begin
      if (xv[i] < x_lo) x_lo = xv[i];
      if (xv[i] > x_hi) x_hi = xv[i];
      if (yv[i] < y_lo) y_lo = yv[i];
      if (yv[i] > y_hi) y_hi = yv[i];
    end
    // everything stops at the screen edge
    if (x_hi > `RASTER_FB_WIDTH - 1) x_hi = `RASTER_FB_WIDTH - 1;
    if (x_lo > `RASTER_FB_WIDTH - 1) x_lo = `RASTER_FB_WIDTH - 1;
    if (y_hi > `RASTER_FB_HEIGHT - 1) y_hi = `RASTER_FB_HEIGHT - 1;
    if (y_lo > `RASTER_FB_HEIGHT - 1) y_lo = `RASTER_FB_HEIGHT - 1;
    return (x_hi - x_lo + 1) * (y_hi - y_lo + 1);
  endfunction

  task automatic wait_pending();
    repeat (pending) @(negedge S_AXI_ACLK);
    pending = 0;
  endtask

  ////////////////////
  // axi write with random bready back-pressure
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    int n;
    int hold;
    @(negedge S_AXI_ACLK);
    S_AXI_AWADDR  = addr;
    S_AXI_WDATA   = data;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID  = 1'b1;
    S_AXI_BREADY  = 1'b0;
    @(negedge S_AXI_ACLK);
    n = 1;
    while (!S_AXI_AWREADY && n < 16) begin
      @(negedge S_AXI_ACLK);
      n++;
    end
    if (!S_AXI_AWREADY) begin
      $display("write to address 0x%0h was never accepted", addr);
      test_errors++;
      S_AXI_AWVALID = 1'b0;
      S_AXI_WVALID  = 1'b0;
      return;
    end
    if (S_AXI_WREADY !== 1'b1) report_mismatch("S_AXI_WREADY", 32'(S_AXI_WREADY), 32'h1);
    // valids must stay up across the ready edge
    @(negedge S_AXI_ACLK);
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;
    if (S_AXI_AWREADY !== 1'b0) report_mismatch("S_AXI_AWREADY", 32'(S_AXI_AWREADY), 32'h0);
    if (S_AXI_WREADY !== 1'b0) report_mismatch("S_AXI_WREADY", 32'(S_AXI_WREADY), 32'h0);
    if (S_AXI_BVALID !== 1'b1) report_mismatch("S_AXI_BVALID", 32'(S_AXI_BVALID), 32'h1);
    if (S_AXI_BRESP !== 2'b00) report_mismatch("S_AXI_BRESP", 32'(S_AXI_BRESP), 32'h0);
    // hold bready low for 1 to 8 cycles
    draw_bits(3, hold);
    repeat (hold + 1) begin
      @(negedge S_AXI_ACLK);
      if (S_AXI_BVALID !== 1'b1) report_mismatch("S_AXI_BVALID", 32'(S_AXI_BVALID), 32'h1);
    end
    S_AXI_BREADY = 1'b1;
    @(negedge S_AXI_ACLK);
    if (S_AXI_BVALID !== 1'b0) report_mismatch("S_AXI_BVALID", 32'(S_AXI_BVALID), 32'h0);
    S_AXI_BREADY = 1'b0;
  endtask

  task automatic commit_triangle(input int base);
    axi_write(4'h0, words[base+1]);
    axi_write(4'h4, words[base+2]);
    axi_write(4'h8, words[base+3]);
    // color word commits the triangle
    axi_write(4'hC, words[base+4]);
    pending += bbox_area(words[base+1], words[base+2], words[base+3]) + 2 + MARGIN;
    close_test($sformatf("triangle color 0x%0h write", words[base+4][7:0]));
  endtask

  task automatic pulse_vsync();
    // controller must be idle to see the edge
    wait_pending();
    @(negedge S_AXI_ACLK);
    vsync = 1'b1;
    repeat (4) @(negedge S_AXI_ACLK);
    vsync = 1'b0;
    pending = CLEAR_CYCLES + MARGIN;
  endtask

  task automatic probe_pixel(input logic [9:0] x, input logic [9:0] y, input logic [7:0] c);
    logic [3:0] red_exp;
    logic [3:0] green_exp;
    logic [3:0] blue_exp;
    // rrrgggbb, zero filled to 4 bits
    red_exp   = {c[7:5], 1'b0};
    green_exp = {c[4:2], 1'b0};
    blue_exp  = {c[1:0], 2'b00};
    wait_pending();
    @(negedge S_AXI_ACLK);
    drawX = x;
    drawY = y;
    // rgb register loads on the next rising edge
    @(negedge S_AXI_ACLK);
    if (red !== red_exp) report_mismatch("red", 32'(red), 32'(red_exp));
    if (green !== green_exp) report_mismatch("green", 32'(green), 32'(green_exp));
    if (blue !== blue_exp) report_mismatch("blue", 32'(blue), 32'(blue_exp));
    close_test($sformatf("probe x %0d y %0d", x, y));
  endtask

  ////////////////////
  // main sequence
  initial begin
    S_AXI_AWADDR  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b0;
    vsync         = 1'b0;
    drawX         = '0;
    drawY         = '0;
    lfsr          = 16'd3408;
    loaded        = 1'b0;
    pending       = 0;
    test_errors   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    for (int i = 0; i < MAX_RECORDS * REC_WORDS; i++) begin
      words[i] = '0;
    end
    $readmemh("tri_raster_tests.txt", words);
    num_records = 0;
    while (num_records < MAX_RECORDS && words[num_records*REC_WORDS] != 32'd0) begin
      num_records++;
    end
    loaded = 1'b1;

    @(posedge S_AXI_ARESETN);
    @(negedge S_AXI_ACLK);
    if (S_AXI_AWREADY !== 1'b0) report_mismatch("S_AXI_AWREADY", 32'(S_AXI_AWREADY), 32'h0);
    if (S_AXI_WREADY !== 1'b0) report_mismatch("S_AXI_WREADY", 32'(S_AXI_WREADY), 32'h0);
    if (S_AXI_BVALID !== 1'b0) report_mismatch("S_AXI_BVALID", 32'(S_AXI_BVALID), 32'h0);
    close_test("reset outputs");
    // buffer clear runs right after reset
    pending = CLEAR_CYCLES + MARGIN;

    for (int r = 0; r < num_records; r++) begin
      case (words[r*REC_WORDS])
        32'd1: commit_triangle(r * REC_WORDS);
        32'd2: pulse_vsync();
        32'd3: probe_pixel(words[r*REC_WORDS+1][9:0], words[r*REC_WORDS+2][9:0],
                           words[r*REC_WORDS+3][7:0]);
        default: begin
          $display("record %0d has an unknown kind", r);
          test_errors++;
          close_test("bad record");
        end
      endcase
    end

    $display("summary: %0d tests, %0d passed, %0d failed", tests_run,
             tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // limit grows with the record count, each record allowed a full clear
  initial begin
    wait (loaded);
    repeat ((num_records + 3) * (CLEAR_CYCLES + 100)) @(posedge S_AXI_ACLK);
    $display("timeout: the test sequence did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- tri_raster_tests.txt
// kind 1 triangle: vertex1 vertex2 vertex3 color (vertex word y<<16 | x)
// kind 2 vsync: unused words; kind 3 probe: drawX drawY expected_color unused
3 00000014 00000014 00000000 00000000
1 000a000a 000a0028 001e0014 000000e3
1 0014001e 0014003c 0032002d 0000001c
3 00000046 00000032 0000001c 00000000
3 0000001e 00000018 000000e3 00000000
3 0000008c 00000028 00000000 00000000
2 00000000 00000000 00000000 00000000
3 00000046 00000032 00000000 00000000
1 0064012c 006e0190 0078015e 0000006f
3 0000027e 000000dc 0000006f 00000000
3 00000256 000000dc 00000000 00000000

//--- tri_raster_top.f
+incdir+.
raster_pkg.sv
axi_tri_regs.sv
tri_fifo.sv
bbox_fill.sv
frame_ctrl.sv
frame_buffer.sv
tri_raster_top.sv
tb_clk_gen.sv
tri_raster_sva.sv
tri_raster_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tri_raster_tb
FILELIST = tri_raster_top.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
